//--- src/testbus_data_pkg.sv
package testbus_data_pkg;

  // Width of every lane debug word and of the test bus itself
  parameter int WORD_W = 16;

  // Probe mode field width, matches the MODE register
  parameter int MODE_W = 2;

  // One test word, as seen on a lane or on the bus
  typedef logic [WORD_W-1:0] test_word_t;

  // Saturation value of the edge counter
  parameter test_word_t WORD_MAX = '1;

  // Probe behaviour, shared by all lanes
  typedef enum logic [MODE_W-1:0] {
    // Word follows the lane input
    PROBE_RAW      = 2'd0,
    // Set bits accumulate until a clear
    PROBE_STICKY   = 2'd1,
    // Counts rising edges on bit 0
    PROBE_EDGE_CNT = 2'd2
  } probe_mode_e;

  // Code 3 is unused; probes fall back to raw for it

endpackage

//--- src/testbus_cfg_pkg.sv
package testbus_cfg_pkg;

  // Lane select field width, bounds the lane count
  parameter int LANE_SEL_W = 4;

  // Rotation amount field width, log2 of the word width
  parameter int ORDER_W = 4;

  // Word addresses on the register bus
  typedef enum logic [1:0] {
    // Enable, lane select and bit order
    ADDR_CTRL  = 2'd0,
    // Probe mode for all lanes
    ADDR_MODE  = 2'd1,
    // Write strobes the probe clear, read gives zero
    ADDR_CLEAR = 2'd2,
    // Live test-bus output, read only
    ADDR_SNAP  = 2'd3
  } reg_addr_e;

  // Monitor control, low bits of ADDR_CTRL
  typedef struct packed {
    logic                  enable;
    logic [LANE_SEL_W-1:0] lane_sel;
    logic [ORDER_W-1:0]    sel_order;
  } testbus_ctrl_t;

  // Bits of ADDR_CTRL that are backed by flops
  parameter int CTRL_W = $bits(testbus_ctrl_t);

  // Wishbone classic request, master to slave
  typedef struct packed {
    logic                         cyc;
    logic                         stb;
    logic                         we;
    reg_addr_e                    adr;
    testbus_data_pkg::test_word_t dat;
  } wb_req_t;

  // Wishbone classic response, slave to master
  typedef struct packed {
    logic                         ack;
    testbus_data_pkg::test_word_t dat;
  } wb_rsp_t;

endpackage

//--- src/testbus_regs.sv
`timescale 1ns/1ps

module testbus_regs (
  input  logic                           clk,
  input  logic                           rst_n,
  input  testbus_cfg_pkg::wb_req_t       wb_req,
  input  testbus_data_pkg::test_word_t   snap_word,
  output testbus_cfg_pkg::wb_rsp_t       wb_rsp,
  output testbus_cfg_pkg::testbus_ctrl_t ctrl,
  output testbus_data_pkg::probe_mode_e  probe_mode,
  output logic                           probe_clear
);

  // Handshake state
  logic                         ack_q;
  logic                         access;
  logic                         wr_en;

  // Read path
  testbus_data_pkg::test_word_t rd_dat_d;
  testbus_data_pkg::test_word_t rd_dat_q;

  // New access only while ack is low
  // Keeps a held request from being acked twice
  assign access = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_en  = access && wb_req.we;

  // Single-cycle ack one edge after the request shows up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Control and mode registers
  // Writes land on the ack edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl       <= '0;
      probe_mode <= testbus_data_pkg::PROBE_RAW;
    end else if (wr_en) begin
      case (wb_req.adr)
        testbus_cfg_pkg::ADDR_CTRL: begin
          ctrl <= testbus_cfg_pkg::testbus_ctrl_t'(
                    wb_req.dat[testbus_cfg_pkg::CTRL_W-1:0]);
        end
        testbus_cfg_pkg::ADDR_MODE: begin
          probe_mode <= testbus_data_pkg::probe_mode_e'(
                          wb_req.dat[testbus_data_pkg::MODE_W-1:0]);
        end
        default: begin
          // Clear and snapshot hold no state here
        end
      endcase
    end
  end

  // Clear strobe high for the ack cycle of a CLEAR write only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      probe_clear <= 1'b0;
    end else begin
      probe_clear <= wr_en && (wb_req.adr == testbus_cfg_pkg::ADDR_CLEAR);
    end
  end

  // Read mux
  // Unbacked upper bits stay zero
  always_comb begin
    rd_dat_d = '0;
    case (wb_req.adr)
      testbus_cfg_pkg::ADDR_CTRL: begin
        rd_dat_d[testbus_cfg_pkg::CTRL_W-1:0] = ctrl;
      end
      testbus_cfg_pkg::ADDR_MODE: begin
        rd_dat_d[testbus_data_pkg::MODE_W-1:0] = probe_mode;
      end
      testbus_cfg_pkg::ADDR_CLEAR: begin
        rd_dat_d = '0;
      end
      testbus_cfg_pkg::ADDR_SNAP: begin
        // Live bus value at the ack edge
        rd_dat_d = snap_word;
      end
      default: begin
        rd_dat_d = '0;
      end
    endcase
  end

  // Read data captured with the ack
  // Writes return zero on dat
  always_ff @(posedge clk) begin
    if (access) begin
      rd_dat_q <= wb_req.we ? '0 : rd_dat_d;
    end
  end

  // Response fields
  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rd_dat_q;

  // Ack never stretches past one cycle
  a_ack_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    ack_q |=> !ack_q
  );

  // Ack only follows a live request from the master
  a_ack_after_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(ack_q) |-> $past(wb_req.cyc && wb_req.stb)
  );

endmodule

//--- src/lane_probe.sv
`timescale 1ns/1ps

module lane_probe (
  input  logic                          clk,
  input  logic                          rst_n,
  input  testbus_data_pkg::test_word_t  lane_dbg,
  input  testbus_data_pkg::probe_mode_e probe_mode,
  input  logic                          probe_clear,
  output testbus_data_pkg::test_word_t  probe_word
);

  // Previous bit 0 sample for edge detect
  logic                         bit0_q;
  logic                         bit0_rise;
  logic                         cnt_full;

  // Next probe word
  testbus_data_pkg::test_word_t word_d;

  // Low at the last edge and high now
  assign bit0_rise = lane_dbg[0] && !bit0_q;

  // Counter stops at all ones
  assign cnt_full = (probe_word == testbus_data_pkg::WORD_MAX);

  always_comb begin
    word_d = probe_word;
    case (probe_mode)
      testbus_data_pkg::PROBE_RAW: begin
        word_d = lane_dbg;
      end
      testbus_data_pkg::PROBE_STICKY: begin
        // Accumulate any bit seen high
        word_d = probe_word | lane_dbg;
      end
      testbus_data_pkg::PROBE_EDGE_CNT: begin
        if (bit0_rise && !cnt_full) begin
          word_d = probe_word + 1'b1;
        end
      end
      default: begin
        // Unused code behaves as raw
        word_d = lane_dbg;
      end
    endcase
    // Clear wins over every mode
    if (probe_clear) begin
      word_d = '0;
    end
  end

  // Probe word register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      probe_word <= '0;
    end else begin
      probe_word <= word_d;
    end
  end

  // Bit 0 history tracked in every mode
  // so a mode switch does not miss the first edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit0_q <= 1'b0;
    end else begin
      bit0_q <= lane_dbg[0];
    end
  end

  // Edge count only moves up
  a_cnt_monotonic: assert property (
    @(posedge clk) disable iff (!rst_n)
    (probe_mode == testbus_data_pkg::PROBE_EDGE_CNT) && !probe_clear
      |=> probe_word >= $past(probe_word)
  );

endmodule

//--- src/testbus_mon_sel.sv
`timescale 1ns/1ps

module testbus_mon_sel #(
  parameter int NUM_LANES = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  testbus_cfg_pkg::testbus_ctrl_t                ctrl,
  input  testbus_data_pkg::test_word_t [NUM_LANES-1:0]  lane_words,
  output testbus_data_pkg::test_word_t                  dig_test_dout
);

  localparam int W = testbus_data_pkg::WORD_W;

  // Lane mux result
  testbus_data_pkg::test_word_t sel_word;
  logic                         lane_hit;

  // Doubled word for the rotate
  logic [2*W-1:0]               rot_dbl;
  testbus_data_pkg::test_word_t rot_word;

  // Next bus value
  testbus_data_pkg::test_word_t dout_d;

  // Lane count must fit the lane_sel field
  if (NUM_LANES < 1 || NUM_LANES > 2**testbus_cfg_pkg::LANE_SEL_W) begin : g_bad_lanes
    $error("testbus_mon_sel: NUM_LANES out of range");
  end

  // Lane select
  // lane_hit stays low for a lane number past the last probe
  always_comb begin
    sel_word = '0;
    lane_hit = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (ctrl.lane_sel == i) begin
        sel_word = lane_words[i];
        lane_hit = 1'b1;
      end
    end
  end

  // Rotate left by sel_order
  // Bit i lands on bit (i + k) mod 16
  // So k = 1 gives {w[14:0], w[15]}
  always_comb begin
    rot_dbl  = {sel_word, sel_word} << ctrl.sel_order;
    rot_word = rot_dbl[2*W-1 -: W];
  end

  // Gate with enable and a valid lane
  assign dout_d = (ctrl.enable && lane_hit) ? rot_word : '0;

  // Output register one edge behind the probes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dig_test_dout <= '0;
    end else begin
      dig_test_dout <= dout_d;
    end
  end

  // Out-of-range lane drives zero
  a_bad_lane_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ctrl.lane_sel >= NUM_LANES) |=> dig_test_dout == '0
  );

endmodule

//--- src/testbus_top.sv
`timescale 1ns/1ps

module testbus_top #(
  parameter int NUM_LANES = 4
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  testbus_cfg_pkg::wb_req_t                     wb_req,
  input  testbus_data_pkg::test_word_t [NUM_LANES-1:0] lane_dbg_in,
  output testbus_cfg_pkg::wb_rsp_t                     wb_rsp,
  output testbus_data_pkg::test_word_t                 dig_test_dout
);

  // Register block outputs
  testbus_cfg_pkg::testbus_ctrl_t               ctrl;
  testbus_data_pkg::probe_mode_e                probe_mode;
  logic                                         probe_clear;

  // Registered probe words, one per lane
  testbus_data_pkg::test_word_t [NUM_LANES-1:0] lane_words;

  // Wishbone slave, reads the bus output back for SNAP
  testbus_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .snap_word   (dig_test_dout),
    .wb_rsp      (wb_rsp),
    .ctrl        (ctrl),
    .probe_mode  (probe_mode),
    .probe_clear (probe_clear)
  );

  // One probe per lane, shared mode and clear
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    lane_probe u_probe (
      .clk         (clk),
      .rst_n       (rst_n),
      .lane_dbg    (lane_dbg_in[g]),
      .probe_mode  (probe_mode),
      .probe_clear (probe_clear),
      .probe_word  (lane_words[g])
    );
  end

  // Lane pick, rotate and output flop
  testbus_mon_sel #(
    .NUM_LANES (NUM_LANES)
  ) u_mon_sel (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl          (ctrl),
    .lane_words    (lane_words),
    .dig_test_dout (dig_test_dout)
  );

endmodule

//--- verification/testbus_tb_tasks.svh
`ifndef TESTBUS_TB_TASKS_SVH
`define TESTBUS_TB_TASKS_SVH

// Expected bus word with bit i moved to bit (i + k) mod 16
function automatic testbus_data_pkg::test_word_t rotate_left(
  input testbus_data_pkg::test_word_t w,
  input int                           k
);
  testbus_data_pkg::test_word_t r;
  r = '0;
  for (int i = 0; i < testbus_data_pkg::WORD_W; i++) begin
    r[(i + k) % testbus_data_pkg::WORD_W] = w[i];
  end
  return r;
endfunction

// Sparse random word with about one bit in eight set
function automatic testbus_data_pkg::test_word_t sparse_word();
  return testbus_data_pkg::test_word_t'($urandom & $urandom & $urandom);
endfunction

task automatic wait_falls(input int n);
  repeat (n) @(negedge clk);
endtask

task automatic protocol_error(input string what);
  $display("%s", what);
  $display("Verification failed");
  $fatal(1, "Stopped on bus protocol error");
endtask

task automatic check_word(
  input testbus_data_pkg::test_word_t actual,
  input testbus_data_pkg::test_word_t expected,
  input string                        what
);
  if (actual !== expected) begin
    $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    $display("Verification failed");
    $fatal(1, "Stopped at first mismatch");
  end
endtask

task automatic check_ctrl(
  input testbus_cfg_pkg::testbus_ctrl_t actual,
  input testbus_cfg_pkg::testbus_ctrl_t expected,
  input string                          what
);
  if (actual !== expected) begin
    $display("Fail at %0t ns: %s, got %p, expected %p", $time, what, actual, expected);
    $display("Verification failed");
    $fatal(1, "Stopped at first mismatch");
  end
endtask

// One classic cycle with the request driven on a falling edge
// Request held until ack
task automatic bus_cycle(
  input  logic                         we,
  input  testbus_cfg_pkg::reg_addr_e   adr,
  input  testbus_data_pkg::test_word_t wdat,
  output testbus_data_pkg::test_word_t rdat
);
  @(negedge clk);
  if (wb_rsp.ack) protocol_error("Bus error: ack high with no request pending");
  wb_req.cyc = 1'b1;
  wb_req.stb = 1'b1;
  wb_req.we  = we;
  wb_req.adr = adr;
  wb_req.dat = wdat;
  @(negedge clk);
  while (!wb_rsp.ack) @(negedge clk);
  rdat   = wb_rsp.dat;
  wb_req = '0;
  // Exactly one ack per access
  @(negedge clk);
  if (wb_rsp.ack) protocol_error("Bus error: ack stayed high for a second cycle");
endtask

task automatic wb_write(
  input testbus_cfg_pkg::reg_addr_e   adr,
  input testbus_data_pkg::test_word_t dat
);
  testbus_data_pkg::test_word_t unused;
  bus_cycle(1'b1, adr, dat, unused);
endtask

task automatic wb_read(
  input  testbus_cfg_pkg::reg_addr_e   adr,
  output testbus_data_pkg::test_word_t dat
);
  bus_cycle(1'b0, adr, '0, dat);
endtask

task automatic write_ctrl(input logic en, input int lane, input int order);
  testbus_cfg_pkg::testbus_ctrl_t c;
  testbus_data_pkg::test_word_t   w;
  c.enable    = en;
  c.lane_sel  = lane[testbus_cfg_pkg::LANE_SEL_W-1:0];
  c.sel_order = order[testbus_cfg_pkg::ORDER_W-1:0];
  w = '0;
  w[testbus_cfg_pkg::CTRL_W-1:0] = c;
  wb_write(testbus_cfg_pkg::ADDR_CTRL, w);
endtask

task automatic reset_and_regs();
  testbus_data_pkg::test_word_t   rd;
  testbus_cfg_pkg::testbus_ctrl_t exp_ctrl;
  wb_read(testbus_cfg_pkg::ADDR_CTRL, rd);
  check_word(rd, '0, "CTRL after reset");
  wb_read(testbus_cfg_pkg::ADDR_MODE, rd);
  check_word(rd, '0, "MODE after reset");
  wb_read(testbus_cfg_pkg::ADDR_SNAP, rd);
  check_word(rd, '0, "SNAP after reset");
  // Upper bits written as ones must read back as zero
  exp_ctrl = '{enable: 1'b1, lane_sel: 4'd3, sel_order: 4'hA};
  wb_write(testbus_cfg_pkg::ADDR_CTRL, 16'hFE00 | 16'(exp_ctrl));
  wb_read(testbus_cfg_pkg::ADDR_CTRL, rd);
  check_ctrl(rd[testbus_cfg_pkg::CTRL_W-1:0], exp_ctrl, "CTRL readback");
  check_word(rd >> testbus_cfg_pkg::CTRL_W, '0, "CTRL upper bits");
  wb_write(testbus_cfg_pkg::ADDR_MODE, 16'(testbus_data_pkg::PROBE_EDGE_CNT));
  wb_read(testbus_cfg_pkg::ADDR_MODE, rd);
  check_word(rd, 16'(testbus_data_pkg::PROBE_EDGE_CNT), "MODE readback");
  wb_read(testbus_cfg_pkg::ADDR_CLEAR, rd);
  check_word(rd, '0, "CLEAR read");
  wb_write(testbus_cfg_pkg::ADDR_MODE, 16'(testbus_data_pkg::PROBE_RAW));
  write_ctrl(1'b0, 0, 0);
endtask

// Every lane and bit order with fresh random inputs each time
task automatic raw_rotation();
  for (int lane = 0; lane < NUM_LANES; lane++) begin
    for (int k = 0; k < testbus_data_pkg::WORD_W; k++) begin
      @(negedge clk);
      for (int i = 0; i < NUM_LANES; i++) begin
        lane_dbg_in[i] = testbus_data_pkg::test_word_t'($urandom);
      end
      write_ctrl(1'b1, lane, k);
      wait_falls(2);
      check_word(dig_test_dout, rotate_left(lane_dbg_in[lane], k),
                 $sformatf("raw lane %0d order %0d", lane, k));
    end
  end
endtask

task automatic output_gating();
  @(negedge clk);
  lane_dbg_in[1] = testbus_data_pkg::test_word_t'($urandom) | 16'h0001;
  write_ctrl(1'b0, 1, 3);
  wait_falls(2);
  check_word(dig_test_dout, '0, "output with enable low");
  // Lane 5 has no probe with four lanes
  write_ctrl(1'b1, 5, 0);
  wait_falls(2);
  check_word(dig_test_dout, '0, "output with lane_sel 5");
endtask

task automatic sticky_mode();
  testbus_data_pkg::test_word_t   acc;
  testbus_data_pkg::test_word_t   rd;
  testbus_cfg_pkg::testbus_ctrl_t exp_ctrl;
  acc = '0;
  wb_write(testbus_cfg_pkg::ADDR_MODE, 16'(testbus_data_pkg::PROBE_STICKY));
  write_ctrl(1'b1, 2, 0);
  exp_ctrl = '{enable: 1'b1, lane_sel: 4'd2, sel_order: 4'd0};
  wb_read(testbus_cfg_pkg::ADDR_CTRL, rd);
  check_ctrl(rd[testbus_cfg_pkg::CTRL_W-1:0], exp_ctrl, "CTRL for sticky test");
  lane_dbg_in[2] = '0;
  wb_write(testbus_cfg_pkg::ADDR_CLEAR, '0);
  repeat (20) begin
    @(negedge clk);
    lane_dbg_in[2] = sparse_word();
    acc |= lane_dbg_in[2];
  end
  wait_falls(2);
  check_word(dig_test_dout, acc, "sticky OR of 20 words");
  lane_dbg_in[2] = '0;
  wb_write(testbus_cfg_pkg::ADDR_CLEAR, '0);
  wait_falls(2);
  check_word(dig_test_dout, '0, "sticky after second clear");
endtask

// One rising edge on bit 0 per two cycles
// Upper bits carry noise
task automatic bit0_pulses(input int lane, input int count);
  repeat (count) begin
    @(negedge clk);
    lane_dbg_in[lane] = testbus_data_pkg::test_word_t'($urandom) | 16'h0001;
    @(negedge clk);
    lane_dbg_in[lane] = testbus_data_pkg::test_word_t'($urandom) & 16'hFFFE;
  end
endtask

task automatic edge_count();
  int n;
  n = 1 + ($urandom % 199);
  wb_write(testbus_cfg_pkg::ADDR_MODE, 16'(testbus_data_pkg::PROBE_EDGE_CNT));
  write_ctrl(1'b1, 1, 0);
  lane_dbg_in[1] = '0;
  wb_write(testbus_cfg_pkg::ADDR_CLEAR, '0);
  bit0_pulses(1, n);
  wait_falls(2);
  check_word(dig_test_dout, 16'(n), $sformatf("edge count after %0d edges", n));
  // Drive past the counter range so it must stick at all ones
  bit0_pulses(1, 65600);
  wait_falls(2);
  check_word(dig_test_dout, testbus_data_pkg::WORD_MAX, "edge count saturation");
endtask

task automatic snapshot_read();
  testbus_data_pkg::test_word_t rd;
  testbus_data_pkg::test_word_t exp_word;
  wb_write(testbus_cfg_pkg::ADDR_MODE, 16'(testbus_data_pkg::PROBE_RAW));
  @(negedge clk);
  lane_dbg_in[0] = testbus_data_pkg::test_word_t'($urandom);
  write_ctrl(1'b1, 0, 5);
  wait_falls(2);
  exp_word = rotate_left(lane_dbg_in[0], 5);
  check_word(dig_test_dout, exp_word, "bus output before SNAP");
  wb_read(testbus_cfg_pkg::ADDR_SNAP, rd);
  check_word(rd, exp_word, "SNAP readback");
endtask

`endif

//--- verification/testbus_tb.sv
`timescale 1ns/1ps

module testbus_tb;

  localparam int NUM_LANES = 4;

  // Edge count test alone takes about 131k cycles
  localparam int TIMEOUT_CYCLES = 200000;

  // DUT ports
  logic                                         clk;
  logic                                         rst_n;
  testbus_cfg_pkg::wb_req_t                     wb_req;
  testbus_data_pkg::test_word_t [NUM_LANES-1:0] lane_dbg_in;
  testbus_cfg_pkg::wb_rsp_t                     wb_rsp;
  testbus_data_pkg::test_word_t                 dig_test_dout;

  // Run bookkeeping
  int cycle_count = 0;

  testbus_top #(
    .NUM_LANES (NUM_LANES)
  ) UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_req        (wb_req),
    .lane_dbg_in   (lane_dbg_in),
    .wb_rsp        (wb_rsp),
    .dig_test_dout (dig_test_dout)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  `include "testbus_tb_tasks.svh"

  // Watchdog on rising edges
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "Run stopped by watchdog");
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    wb_req      = '0;
    lane_dbg_in = '0;
    void'($urandom(92));

    // Four rising edges in reset
    // Release lands on a falling edge
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    reset_and_regs();
    raw_rotation();
    output_gating();
    sticky_mode();
    edge_count();
    snapshot_read();

    $display("Verification passed");
    $finish;
  end

endmodule

//--- list.f
+incdir+verification
src/testbus_data_pkg.sv
src/testbus_cfg_pkg.sv
src/testbus_regs.sv
src/lane_probe.sv
src/testbus_mon_sel.sv
src/testbus_top.sv
verification/testbus_tb.sv
